/* Bender.yml */
package:
  name: cam_frame_path

sources:
  - src/cam_pkg.sv
  - src/ov7670_capture.sv
  - src/frame_buffer.sv
  - src/frame_sequencer.sv
  - src/pixel_fifo.sv
  - src/vga_timing.sv
  - src/cam_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_cam_top.sv

/* dv/tb_cam_model.svh */
//==========================================================================
// testbench model of the camera frames and the expected display colour
// included inside tb_cam_top, uses its IMG_W and IMG_H
// a frame counts as complete once its closing vsync has risen
//==========================================================================
`ifndef TB_CAM_MODEL_SVH
`define TB_CAM_MODEL_SVH

// one displayed colour, 8 bits per channel
typedef struct packed {
	rgb8_t r;
	rgb8_t g;
	rgb8_t b;
} colour_t;

// LCG state, fixed seed for a repeatable run
logic [31:0] lcg_state = 32'hd1bb22bc;

// pixels of each camera frame in raster order, as captured RGB444
pixel_t frame_mem [NUM_FRAMES][IMG_W * IMG_H];

// index of the most recently completed frame, -1 before the first one
int latest_frame = -1;

function automatic logic [7:0] next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	// upper bits have the longer period
	return lcg_state[23:16];
endfunction

// display colour at image position x, y when showing a given frame
function automatic colour_t expected_pixel(input int frame, input int x, input int y);
	pixel_t  p;
	colour_t c;
	c = '0;
	if (frame >= 0 && x < IMG_W && y < IMG_H) begin
		p = frame_mem[frame][y * IMG_W + x];
		// each nibble repeated into both halves of the byte
		c.r = {p[11:8], p[11:8]};
		c.g = {p[7:4], p[7:4]};
		c.b = {p[3:0], p[3:0]};
	end
	return c;
endfunction

`endif

/* dv/tb_cam_top.sv */
//==========================================================================
// testbench for the camera to VGA frame path
// 8x4 image on a 16x8 active raster with short porches, FIFO depth 4
// camera frames start right after a display vsync fall, so each frame
// completes after that display frame has already latched its bank
// inputs change on the rising edge and outputs are sampled on the falling one
//==========================================================================
`timescale 1ns/1ps

module tb_cam_top import cam_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int IMG_W      = 8;
	localparam int IMG_H      = 4;
	localparam int H_ACTIVE   = 16;
	localparam int H_FRONT    = 2;
	localparam int H_SYNC     = 3;
	localparam int H_BACK     = 3;
	localparam int V_ACTIVE   = 8;
	localparam int V_FRONT    = 1;
	localparam int V_SYNC     = 2;
	localparam int V_BACK     = 2;
	localparam int FIFO_DEPTH = 4;
	localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int NUM_FRAMES = 2;
	// seven full display frames plus the partial one before the first vsync
	localparam int TEST_FRAMES = 8;
	localparam int WATCHDOG_NS = 2 * TEST_FRAMES * H_TOTAL * V_TOTAL * CLK_PERIOD;
	// syncs high and blank_n low with black colour
	localparam vga_out_t RESET_VGA = {1'b1, 1'b1, 1'b0, 24'h000000};

	logic       clk;
	logic       rst;
	logic       cam_vsync;
	logic       cam_href;
	logic [7:0] cam_data;
	vga_out_t   vga;

	`include "tb_cam_model.svh"

	// monitor state and the raster position of the sampled output pixel
	logic    first_sample = 1'b1;
	logic    locked = 1'b0;
	logic    prev_hsync = 1'b1;
	logic    prev_vsync = 1'b1;
	// the raster leaves the origin on the first clock after reset
	int      mx = 0;
	int      my = 0;
	int      line_count;
	int      active_count;
	int      h_low;
	int      v_low;
	int      disp_frames;
	int      shown_frame = -1;
	int      shown_count [NUM_FRAMES];

	cam_top #(
		.IMG_W      (IMG_W),
		.IMG_H      (IMG_H),
		.H_ACTIVE   (H_ACTIVE),
		.H_FRONT    (H_FRONT),
		.H_SYNC     (H_SYNC),
		.H_BACK     (H_BACK),
		.V_ACTIVE   (V_ACTIVE),
		.V_FRONT    (V_FRONT),
		.V_SYNC     (V_SYNC),
		.V_BACK     (V_BACK),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (
		.clk          (clk),
		.rst          (rst),
		.ov7670_vsync (cam_vsync),
		.ov7670_href  (cam_href),
		.ov7670_data  (cam_data),
		.vga          (vga)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_vga(input vga_out_t got, input vga_out_t exp, input string what);
		if (got.hsync !== exp.hsync || got.vsync !== exp.vsync ||
				got.blank_n !== exp.blank_n) begin
			$display("Fail %0t: %s hsync/vsync/blank_n got %b%b%b expected %b%b%b", $time,
				what, got.hsync, got.vsync, got.blank_n, exp.hsync, exp.vsync, exp.blank_n);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_rgb(input rgb8_t got, input rgb8_t exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// camera side drives one byte or idle cycle per clock
	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		cam_href <= 1'b1;
		cam_data <= b;
	endtask

	task automatic cam_idle();
		@(posedge clk);
		cam_href <= 1'b0;
		cam_data <= 8'h00;
	endtask

	task automatic vsync_pulse();
		@(posedge clk);
		cam_vsync <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		cam_vsync <= 1'b0;
	endtask

	// random frame with optional idle gaps between byte pairs inside a line
	task automatic send_frame(input int idx, input logic gaps);
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] r;
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				b0 = next_rand();
				b1 = next_rand();
				send_byte(b0);
				send_byte(b1);
				// red from the low nibble of the first byte and g and b from the second
				frame_mem[idx][y * IMG_W + x] = {b0[3:0], b1};
				r = next_rand();
				if (gaps && r[0]) begin
					cam_idle();
				end
			end
			cam_idle();
		end
		// the closing vsync rise completes the frame
		vsync_pulse();
		latest_frame = idx;
	endtask

	task automatic wait_display_frames(input int n);
		int target;
		target = disp_frames + n;
		while (disp_frames < target) begin
			@(posedge clk);
		end
	endtask

	// compare one output sample against the raster position and the model
	task automatic compare_sample();
		vga_out_t exp;
		colour_t  col;
		exp = '0;
		exp.hsync   = !(mx >= H_ACTIVE + H_FRONT && mx < H_ACTIVE + H_FRONT + H_SYNC);
		exp.vsync   = !(my >= V_ACTIVE + V_FRONT && my < V_ACTIVE + V_FRONT + V_SYNC);
		exp.blank_n = (mx < H_ACTIVE) && (my < V_ACTIVE);
		check_vga(vga, exp, $sformatf("x=%0d y=%0d", mx, my));
		// blanking and the area right of and below the image come out black
		col = expected_pixel(shown_frame, mx, my);
		check_rgb(vga.r, col.r, $sformatf("red at x=%0d y=%0d", mx, my));
		check_rgb(vga.g, col.g, $sformatf("green at x=%0d y=%0d", mx, my));
		check_rgb(vga.b, col.b, $sformatf("blue at x=%0d y=%0d", mx, my));
		if (!vga.hsync) begin
			h_low++;
		end
		if (!vga.vsync) begin
			v_low++;
		end
		if (prev_hsync && !vga.hsync) begin
			line_count++;
		end
		if (!prev_hsync && vga.hsync) begin
			check_count(h_low, H_SYNC, "hsync low width in clocks");
			h_low = 0;
		end
		if (!prev_vsync && vga.vsync) begin
			check_count(v_low, V_SYNC * H_TOTAL, "vsync low width in clocks");
			v_low = 0;
		end
		if (vga.blank_n) begin
			active_count++;
		end
		mx++;
		if (mx == H_TOTAL) begin
			mx = 0;
			my = (my == V_TOTAL - 1) ? 0 : my + 1;
		end
	endtask

	// display monitor follows the raster from reset and counts whole frames
	// from the first vsync fall on
	always @(negedge clk) begin
		if (!rst) begin
			if (prev_vsync && !vga.vsync) begin
				if (locked) begin
					check_count(line_count, V_TOTAL, "hsync pulses per frame");
					check_count(active_count, H_ACTIVE * V_ACTIVE, "active pixels per frame");
					if (shown_frame >= 0) begin
						shown_count[shown_frame]++;
					end
				end
				locked       = 1'b1;
				mx           = 0;
				my           = V_ACTIVE + V_FRONT;
				line_count   = 0;
				active_count = 0;
				h_low        = 0;
				v_low        = 0;
				// same choice the sequencer makes at frame_start
				shown_frame  = latest_frame;
				disp_frames++;
			end
			if (first_sample) begin
				// output register still holds its reset value here
				check_vga(vga, RESET_VGA, "output after reset");
				check_rgb(vga.r, 8'h00, "red after reset");
				check_rgb(vga.g, 8'h00, "green after reset");
				check_rgb(vga.b, 8'h00, "blue after reset");
				first_sample = 1'b0;
			end else begin
				compare_sample();
			end
			prev_hsync = vga.hsync;
			prev_vsync = vga.vsync;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Error: watchdog expired, the display never produced the expected frames");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	initial begin
		rst       = 1'b1;
		cam_vsync = 1'b0;
		cam_href  = 1'b0;
		cam_data  = 8'h00;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// black display frames before any camera data
		wait_display_frames(2);
		// lone vsync with no pixels gives no frame_done
		vsync_pulse();
		send_frame(0, 1'b0);
		wait_display_frames(2);
		// second frame with gaps inside lines and then an empty vsync
		send_frame(1, 1'b1);
		vsync_pulse();
		wait_display_frames(3);
		check_count(shown_count[0], 2, "display frames showing camera frame 0");
		check_count(shown_count[1], 2, "display frames showing camera frame 1");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* src/cam_pkg.sv */
//==========================================================================
// shared types for the camera to display path
// pixels are RGB444 in red, green, blue nibble order
// pix_addr_t covers up to 320x240 pixels within one bank
// no timescale here, the package holds no module
//==========================================================================

package cam_pkg;

	// one RGB444 pixel, red in [11:8], green in [7:4], blue in [3:0]
	typedef logic [11:0] pixel_t;

	// pixel index within one frame buffer bank
	typedef logic [16:0] pix_addr_t;

	// frame buffer bank select
	typedef logic bank_t;

	// raster counter value
	typedef logic [10:0] coord_t;

	// one 8-bit display colour channel
	typedef logic [7:0] rgb8_t;

	// frame buffer write request from the capture side
	typedef struct packed {
		logic      en;
		bank_t     bank;
		pix_addr_t addr;
		pixel_t    data;
	} fb_wr_t;

	// VGA output bundle, syncs active low
	typedef struct packed {
		logic  hsync;
		logic  vsync;
		logic  blank_n;
		rgb8_t r;
		rgb8_t g;
		rgb8_t b;
	} vga_out_t;

	// widen a nibble to 8 bits by repeating it, 4'hf gives 8'hff
	function automatic rgb8_t expand4(input logic [3:0] nib);
		return {nib, nib};
	endfunction

endpackage

/* src/cam_top.sv */
//==========================================================================
// camera to VGA frame path in a single clock domain
// no SCCB setup, PLL or camera clock and power pins
// the camera byte stream must already be synchronous to clk
// the image is shown 1:1, FIFO_DEPTH of 4 or more keeps up with a full line
//==========================================================================
`timescale 1ns/1ps

module cam_top import cam_pkg::*; #(
	parameter int IMG_W      = 320,
	parameter int IMG_H      = 240,
	parameter int H_ACTIVE   = 640,
	parameter int H_FRONT    = 16,
	parameter int H_SYNC     = 96,
	parameter int H_BACK     = 48,
	parameter int V_ACTIVE   = 480,
	parameter int V_FRONT    = 10,
	parameter int V_SYNC     = 2,
	parameter int V_BACK     = 33,
	parameter int FIFO_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       ov7670_vsync,
	input  logic       ov7670_href,
	input  logic [7:0] ov7670_data,
	output vga_out_t   vga
);

	fb_wr_t    fb_wr;
	bank_t     cap_bank;
	bank_t     rd_bank;
	pix_addr_t rd_addr;
	pixel_t    rd_data;
	pixel_t    push_data;
	pixel_t    head_data;
	logic      frame_done;
	logic      frame_start;
	logic      credit_return;
	logic      rd_en;
	logic      push;
	logic      pop;
	logic      scanning;

	// camera bytes into the capture bank
	ov7670_capture inst_ov7670_capture (
		.clk        (clk),
		.rst        (rst),
		.vsync      (ov7670_vsync),
		.href       (ov7670_href),
		.d          (ov7670_data),
		.cap_bank   (cap_bank),
		.wr         (fb_wr),
		.frame_done (frame_done)
	);

	frame_buffer #(
		.IMG_W (IMG_W),
		.IMG_H (IMG_H)
	) inst_frame_buffer (
		.clk     (clk),
		.wr      (fb_wr),
		.rd_en   (rd_en),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// bank swap and credit loop control
	frame_sequencer #(
		.IMG_W      (IMG_W),
		.IMG_H      (IMG_H),
		.FIFO_DEPTH (FIFO_DEPTH)
	) inst_frame_sequencer (
		.clk           (clk),
		.rst           (rst),
		.frame_done    (frame_done),
		.frame_start   (frame_start),
		.credit_return (credit_return),
		.rd_data       (rd_data),
		.cap_bank      (cap_bank),
		.rd_en         (rd_en),
		.rd_bank       (rd_bank),
		.rd_addr       (rd_addr),
		.push          (push),
		.push_data     (push_data),
		.scanning      (scanning)
	);

	pixel_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) inst_pixel_fifo (
		.clk           (clk),
		.rst           (rst),
		.push          (push),
		.push_data     (push_data),
		.pop           (pop),
		.head_data     (head_data),
		.credit_return (credit_return)
	);

	// raster side, pops pixels in display order
	vga_timing #(
		.IMG_W    (IMG_W),
		.IMG_H    (IMG_H),
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) inst_vga_timing (
		.clk         (clk),
		.rst         (rst),
		.scanning    (scanning),
		.head_data   (head_data),
		.pop         (pop),
		.frame_start (frame_start),
		.vga         (vga)
	);

endmodule

/* src/frame_buffer.sv */
//==========================================================================
// two-bank pixel RAM, one write port and one registered read port
// each bank holds IMG_W*IMG_H pixels, bank 1 sits above bank 0
// rd_data is valid in the cycle after rd_en
//==========================================================================
`timescale 1ns/1ps

module frame_buffer import cam_pkg::*; #(
	parameter int IMG_W = 320,
	parameter int IMG_H = 240
) (
	input  logic      clk,
	input  fb_wr_t    wr,
	input  logic      rd_en,
	input  bank_t     rd_bank,
	input  pix_addr_t rd_addr,
	output pixel_t    rd_data
);

	localparam int DEPTH = IMG_W * IMG_H;
	localparam int IW    = $clog2(2 * DEPTH);

	pixel_t        mem [2 * DEPTH];
	logic [IW-1:0] wr_idx;
	logic [IW-1:0] rd_idx;

	// bank folded in as an offset of one bank size
	assign wr_idx = wr.bank ? IW'(DEPTH) + IW'(wr.addr) : IW'(wr.addr);
	assign rd_idx = rd_bank ? IW'(DEPTH) + IW'(rd_addr) : IW'(rd_addr);

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr_idx] <= wr.data;
		end
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

/* src/frame_sequencer.sv */
//==========================================================================
// bank control and credit-limited frame buffer reads
// FIFO_DEPTH must match the pixel FIFO so a push always finds room
// a scan started at frame_start must finish before the next frame_start
// scanning stays high once the first frame has been shown
//==========================================================================
`timescale 1ns/1ps

module frame_sequencer import cam_pkg::*; #(
	parameter int IMG_W      = 320,
	parameter int IMG_H      = 240,
	parameter int FIFO_DEPTH = 8
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      frame_done,
	input  logic      frame_start,
	input  logic      credit_return,
	input  pixel_t    rd_data,
	output bank_t     cap_bank,
	output logic      rd_en,
	output bank_t     rd_bank,
	output pix_addr_t rd_addr,
	output logic      push,
	output pixel_t    push_data,
	output logic      scanning
);

	localparam int        CW        = $clog2(FIFO_DEPTH + 1);
	localparam pix_addr_t LAST_ADDR = pix_addr_t'(IMG_W * IMG_H - 1);

	// IDLE until a frame completes, then WAIT_FRAME and SCAN alternate
	typedef enum logic [1:0] {
		IDLE,
		WAIT_FRAME,
		SCAN
	} seq_state_t;

	seq_state_t    state;
	bank_t         latest_bank;
	bank_t         disp_bank;
	logic [CW-1:0] credits;
	pix_addr_t     addr;
	logic          issue;

	// one read per cycle while credits remain
	assign issue     = (state == SCAN) && (credits != '0);
	assign rd_en     = issue;
	assign rd_bank   = disp_bank;
	assign rd_addr   = addr;
	// RAM output lines up with the delayed push
	assign push_data = rd_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= IDLE;
			cap_bank    <= 1'b0;
			latest_bank <= 1'b0;
			disp_bank   <= 1'b0;
			credits     <= CW'(FIFO_DEPTH);
			addr        <= '0;
			push        <= 1'b0;
			scanning    <= 1'b0;
		end else begin
			// matches the one-cycle RAM read latency
			push    <= issue;
			credits <= credits - CW'(issue) + CW'(credit_return);
			// completed bank becomes latest, capture moves to the other one
			if (frame_done) begin
				latest_bank <= cap_bank;
				cap_bank    <= ~cap_bank;
			end
			case (state)
				IDLE: begin
					if (frame_done) begin
						state <= WAIT_FRAME;
					end
				end
				WAIT_FRAME: begin
					if (frame_start) begin
						disp_bank <= latest_bank;
						addr      <= '0;
						scanning  <= 1'b1;
						state     <= SCAN;
					end
				end
				SCAN: begin
					if (issue) begin
						addr <= addr + 1'b1;
						// final read ends the scan
						if (addr == LAST_ADDR) begin
							state <= WAIT_FRAME;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* src/ov7670_capture.sv */
//==========================================================================
// OV7670 byte stream to RGB444 pixel writes
// the byte stream must be synchronous to clk, there is no pclk domain
// first byte of a pair holds red in its low nibble, second holds g and b
// frame_done only follows a vsync rise when pixels were written before it
//==========================================================================
`timescale 1ns/1ps

module ov7670_capture import cam_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       vsync,
	input  logic       href,
	input  logic [7:0] d,
	input  bank_t      cap_bank,
	output fb_wr_t     wr,
	output logic       frame_done
);

	logic       vsync_q;
	logic       vsync_rise;
	// 0 on the first byte of a pair, 1 on the second
	logic       phase;
	logic       second_byte;
	logic [3:0] red_q;
	pix_addr_t  addr_cnt;
	// at least one pixel written since the last frame_done
	logic       got_pix;
	logic       wr_en;
	bank_t      wr_bank;
	pix_addr_t  wr_addr;
	pixel_t     wr_data;

	assign vsync_rise  = vsync & ~vsync_q;
	assign second_byte = href & phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			vsync_q    <= 1'b0;
			phase      <= 1'b0;
			addr_cnt   <= '0;
			got_pix    <= 1'b0;
			frame_done <= 1'b0;
			wr_en      <= 1'b0;
		end else begin
			vsync_q    <= vsync;
			// byte phase restarts on every href low cycle
			phase      <= href ? ~phase : 1'b0;
			// write lands one cycle after the second byte
			wr_en      <= second_byte;
			frame_done <= vsync_rise & got_pix;
			if (vsync_rise) begin
				addr_cnt <= '0;
				got_pix  <= 1'b0;
			end else if (second_byte) begin
				addr_cnt <= addr_cnt + 1'b1;
				got_pix  <= 1'b1;
			end
		end
	end

	// byte hold and pixel assembly
	always_ff @(posedge clk) begin
		if (href && !phase) begin
			red_q <= d[3:0];
		end
		if (second_byte) begin
			wr_bank <= cap_bank;
			wr_addr <= addr_cnt;
			wr_data <= {red_q, d};
		end
	end

	assign wr = '{en: wr_en, bank: wr_bank, addr: wr_addr, data: wr_data};

endmodule

/* src/pixel_fifo.sv */
//==========================================================================
// pixel FIFO between the frame buffer and the raster
// no full or ready flag, the upstream credit count keeps it from overflowing
// head_data is combinational from the read pointer
//==========================================================================
`timescale 1ns/1ps

module pixel_fifo import cam_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   push,
	input  pixel_t push_data,
	input  logic   pop,
	output pixel_t head_data,
	output logic   credit_return
);

	localparam int            PW       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [PW-1:0] LAST_PTR = PW'(FIFO_DEPTH - 1);

	pixel_t        mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;

	// wrap for depths that are not a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// one credit back per pop, a cycle later
			credit_return <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign head_data = mem[rd_ptr];

endmodule

/* src/vga_timing.sv */
//==========================================================================
// raster counters, syncs and colour output
// line and frame order is active, front porch, sync, back porch
// syncs are active low, the image sits at the top left of the active area
// colour and syncs are registered one cycle behind the counters
//==========================================================================
`timescale 1ns/1ps

module vga_timing import cam_pkg::*; #(
	parameter int IMG_W    = 320,
	parameter int IMG_H    = 240,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     scanning,
	input  pixel_t   head_data,
	output logic     pop,
	output logic     frame_start,
	output vga_out_t vga
);

	// window edges as counter values
	localparam coord_t H_SYNC_BEG = coord_t'(H_ACTIVE + H_FRONT);
	localparam coord_t H_SYNC_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam coord_t H_LAST     = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
	localparam coord_t V_SYNC_BEG = coord_t'(V_ACTIVE + V_FRONT);
	localparam coord_t V_SYNC_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam coord_t V_LAST     = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

	coord_t h_cnt;
	coord_t v_cnt;
	logic   active;
	logic   in_image;

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? coord_t'(0) : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign active   = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
	assign in_image = (h_cnt < coord_t'(IMG_W)) && (v_cnt < coord_t'(IMG_H));
	// one pixel consumed per image pixel while a scan is running
	assign pop      = active && in_image && scanning;
	// first clock of the vertical back porch
	assign frame_start = (h_cnt == '0) && (v_cnt == V_SYNC_END);

	always_ff @(posedge clk) begin
		if (rst) begin
			vga <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0, r: '0, g: '0, b: '0};
		end else begin
			vga.hsync   <= !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
			vga.vsync   <= !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));
			vga.blank_n <= active;
			// black outside the image and before the first scan
			vga.r <= pop ? expand4(head_data[11:8]) : rgb8_t'(0);
			vga.g <= pop ? expand4(head_data[7:4]) : rgb8_t'(0);
			vga.b <= pop ? expand4(head_data[3:0]) : rgb8_t'(0);
		end
	end

endmodule

/* verilog.f */
+incdir+dv
src/cam_pkg.sv
src/ov7670_capture.sv
src/frame_buffer.sv
src/frame_sequencer.sv
src/pixel_fifo.sv
src/vga_timing.sv
src/cam_top.sv
dv/tb_cam_top.sv
